// File: test/configGolden.txt
# stimulus: U byte | A offset data | R offset status | J data | W cycles (all hex but W)
# expected: E frame row data | L frame
W 4
A 0 fab0fab1 A 0 00000100
A 0 5a0c3e71 A 0 9d42b806 A 0 1f7e5c23 A 0 c38a0d94
A 0 6b15f2e8 A 0 04d9a7b3 A 0 e2603c5f A 0 7fa1184d
A 0 b8c45e02 A 0 2d9f6a71 A 0 93e07bc6 A 0 48b2d51a
A 0 f15c0e87 A 0 0a7d39f4 A 0 d6e34b28 A 0 6c08a5d9
E 100 0 5a0c3e71 E 100 1 9d42b806 E 100 2 1f7e5c23 E 100 3 c38a0d94
E 100 4 6b15f2e8 E 100 5 04d9a7b3 E 100 6 e2603c5f E 100 7 7fa1184d
E 100 8 b8c45e02 E 100 9 2d9f6a71 E 100 a 93e07bc6 E 100 b 48b2d51a
E 100 c f15c0e87 E 100 d 0a7d39f4 E 100 e d6e34b28 E 100 f 6c08a5d9
L 100
R 4 00000004 A 4 12345678
A 0 00100000 A 0 11111111 A 0 22222222 R 4 00000000
A 0 fab0fab1 A 0 00000150 A 0 aaaa0000 A 0 aaaa0001 A 0 aaaa0002
E 150 0 aaaa0000 E 150 1 aaaa0001 E 150 2 aaaa0002
U 81 R 4 00000001
U fa U b0 U fa U b1 U 00 U 00 U 02 U 00
U 01 U 23 U 45 U 67 A 0 deadbeef U 89 U ab U cd U ef
U fe U dc U ba U 98 U 76 U 54 U 32 U 10
U 0f U 1e U 2d U 3c U 4b U 5a U 69 U 78
U 87 U 96 U a5 U b4 U c3 U d2 U e1 U f0
U 13 U 57 U 9b U df U 24 U 68 U ac U e0
U 55 U aa U 33 U cc U 0f U f0 U f0 U 0f
U 12 U 48 U ed U b7 U 7e U 81 U c3 U 3c
U 9a U 0b U 8c U 1d U e5 U f6 U 07 U 18
E 200 0 01234567 E 200 1 89abcdef E 200 2 fedcba98 E 200 3 76543210
E 200 4 0f1e2d3c E 200 5 4b5a6978 E 200 6 8796a5b4 E 200 7 c3d2e1f0
E 200 8 13579bdf E 200 9 2468ace0 E 200 a 55aa33cc E 200 b 0ff0f00f
E 200 c 1248edb7 E 200 d 7e81c33c E 200 e 9a0b8c1d E 200 f e5f60718
L 200
W 250 R 4 00000004
J 00000000 J fab0fab1 J 00000300
J c0de0000 J c0de0001 J c0de0002 J c0de0003 J c0de0004 J c0de0005 J c0de0006 J c0de0007
J c0de0008 J c0de0009 J c0de000a J c0de000b J c0de000c J c0de000d J c0de000e J c0de000f
J 00000301
J 0badf000 J 0badf001 J 0badf002 J 0badf003 J 0badf004 J 0badf005 J 0badf006 J 0badf007
J 0badf008 J 0badf009 J 0badf00a J 0badf00b J 0badf00c J 0badf00d J 0badf00e J 0badf00f
E 300 0 c0de0000 E 300 1 c0de0001 E 300 2 c0de0002 E 300 3 c0de0003
E 300 4 c0de0004 E 300 5 c0de0005 E 300 6 c0de0006 E 300 7 c0de0007
E 300 8 c0de0008 E 300 9 c0de0009 E 300 a c0de000a E 300 b c0de000b
E 300 c c0de000c E 300 d c0de000d E 300 e c0de000e E 300 f c0de000f
L 300
E 301 0 0badf000 E 301 1 0badf001 E 301 2 0badf002 E 301 3 0badf003
E 301 4 0badf004 E 301 5 0badf005 E 301 6 0badf006 E 301 7 0badf007
E 301 8 0badf008 E 301 9 0badf009 E 301 a 0badf00a E 301 b 0badf00b
E 301 c 0badf00c E 301 d 0badf00d E 301 e 0badf00e E 301 f 0badf00f
L 301
W 10

// File: all.f
+incdir+include
rtl/configPkg.sv
rtl/configUart.sv
rtl/configApbPort.sv
rtl/configFsm.sv
rtl/eFpgaConfig.sv
test/configChecker.sv
test/tbEFpgaConfig.sv

// File: runSim.sh
#!/bin/sh
# build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tbEFpgaConfig -f all.f \
    --Mdir obj_dir -o simTb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: test/tbEFpgaConfig.sv
`timescale 1ns/1ps
`include "eFpgaConfig_cfg.svh"

module tbEFpgaConfig
    import configPkg::*;
();

    localparam string GoldenFile = "test/configGolden.txt";

    logic       CLK;
    logic       arstN;
    logic       Rx;
    logic       PSEL;
    logic       PENABLE;
    logic       PWRITE;
    apbAddrT    PADDR;
    configWordT PWDATA;
    configWordT PRDATA;
    logic       PREADY;
    logic       PSLVERR;
    logic       jtagActive;
    configWordT jtagWriteData;
    logic       jtagWriteStrobe;
    configWordT configWriteData;
    logic       configWriteStrobe;
    frameAddrT  frameAddressRegister;
    rowSelT     rowSelect;
    logic       longFrameStrobe;
    logic       comActive;
    logic       receiveLed;

    int driverErrors;
    int checkerErrors;
    int pendingCount;
    int cycleCount;
    int cycleLimit;

    // uart led model, one toggle per completed word of a packet
    logic ledExpected;
    logic packetOpen;
    int   packetBytes;

    eFpgaConfig UUT (
        .CLK                 (CLK),
        .arstN               (arstN),
        .Rx                  (Rx),
        .PSEL                (PSEL),
        .PENABLE             (PENABLE),
        .PWRITE              (PWRITE),
        .PADDR               (PADDR),
        .PWDATA              (PWDATA),
        .PRDATA              (PRDATA),
        .PREADY              (PREADY),
        .PSLVERR             (PSLVERR),
        .jtagActive          (jtagActive),
        .jtagWriteData       (jtagWriteData),
        .jtagWriteStrobe     (jtagWriteStrobe),
        .configWriteData     (configWriteData),
        .configWriteStrobe   (configWriteStrobe),
        .frameAddressRegister(frameAddressRegister),
        .rowSelect           (rowSelect),
        .longFrameStrobe     (longFrameStrobe),
        .comActive           (comActive),
        .receiveLed          (receiveLed)
    );

    configChecker chkInst (
        .CLK                 (CLK),
        .configWriteData     (configWriteData),
        .configWriteStrobe   (configWriteStrobe),
        .frameAddressRegister(frameAddressRegister),
        .rowSelect           (rowSelect),
        .longFrameStrobe     (longFrameStrobe),
        .errorCount          (checkerErrors),
        .pendingCount        (pendingCount)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // limit is zero until the golden file has been sized
    always @(posedge CLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit != 0 && cycleCount > cycleLimit) begin
            $display("timeout after %0d cycles, the run did not finish", cycleCount);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic reportMismatch(input string what, input configWordT got,
                                  input configWordT expected);
        $display("** Error at %0t: %s got %h expected %h", $time, what, got, expected);
        driverErrors++;
    endtask

    // a packet opens on the start byte, every fourth byte after it ends a word
    task automatic trackUartByte(input uartByteT value);
        if (!packetOpen) begin
            packetOpen  = (value == `CFG_UART_START_BYTE);
            packetBytes = 0;
        end else begin
            packetBytes++;
            if (packetBytes % 4 == 0) ledExpected = ~ledExpected;
        end
    endtask

    // 8N1, lsb first
    task automatic uartByte(input uartByteT value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge CLK);
            Rx <= frame[i];
            repeat (`CFG_UART_BIT_CYCLES - 1) @(posedge CLK);
        end
    endtask

    // setup, access, idle; pready is always high
    task automatic apbAccess(input logic write, input apbAddrT offset,
                             input configWordT data, input configWordT expected);
        logic errExpected;
        @(posedge CLK);
        PSEL    <= 1'b1;
        PENABLE <= 1'b0;
        PWRITE  <= write;
        PADDR   <= offset;
        PWDATA  <= write ? data : '0;
        @(posedge CLK);
        PENABLE <= 1'b1;
        @(negedge CLK);
        errExpected = write ? (offset != `CFG_APB_DATA_OFFSET)
                            : (offset != `CFG_APB_DATA_OFFSET &&
                               offset != `CFG_APB_STATUS_OFFSET);
        if (PREADY !== 1'b1) begin
            reportMismatch("PREADY", {31'd0, PREADY}, 32'd1);
        end
        if (PSLVERR !== errExpected) begin
            reportMismatch("PSLVERR", {31'd0, PSLVERR}, {31'd0, errExpected});
        end
        if (!write && !errExpected && PRDATA !== expected) begin
            reportMismatch("status read", PRDATA, expected);
        end
        // status bit 0 mirrors the comActive pin
        if (!write && offset == `CFG_APB_STATUS_OFFSET && comActive !== expected[0]) begin
            reportMismatch("comActive", {31'd0, comActive}, {31'd0, expected[0]});
        end
        @(posedge CLK);
        PSEL    <= 1'b0;
        PENABLE <= 1'b0;
    endtask

    // led flips for the strobe cycle of a jtag word
    task automatic jtagWord(input configWordT data);
        @(posedge CLK);
        jtagActive      <= 1'b1;
        jtagWriteStrobe <= 1'b1;
        jtagWriteData   <= data;
        @(negedge CLK);
        if (receiveLed !== ~ledExpected) begin
            reportMismatch("receiveLed", {31'd0, receiveLed}, {31'd0, ~ledExpected});
        end
        @(posedge CLK);
        jtagWriteStrobe <= 1'b0;
    endtask

    // apply == 0 only sums up the cycle length of the records
    task automatic processGolden(input logic apply, output int cycles);
        int          fd;
        int          rc;
        string       tok;
        string       line;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        cycles = 0;
        fd = $fopen(GoldenFile, "r");
        if (fd == 0) begin
            $display("could not open %s", GoldenFile);
            driverErrors++;
            return;
        end
        while (1) begin
            rc = $fscanf(fd, " %s", tok);
            if (rc != 1) break;
            // jtag stays active only across consecutive J records
            if (apply && tok != "J") jtagActive <= 1'b0;
            if (tok == "#") begin
                rc = $fgets(line, fd);
            end else if (tok == "U") begin
                rc = $fscanf(fd, " %h", a);
                cycles += `CFG_UART_BIT_CYCLES * 10;
                if (apply) begin
                    uartByte(a[7:0]);
                    trackUartByte(a[7:0]);
                    @(negedge CLK);
                    if (receiveLed !== ledExpected) begin
                        reportMismatch("receiveLed", {31'd0, receiveLed},
                                       {31'd0, ledExpected});
                    end
                end
            end else if (tok == "A" || tok == "R") begin
                rc = $fscanf(fd, " %h %h", a, b);
                cycles += 3;
                if (apply) apbAccess(tok == "A", a[7:0], b, b);
            end else if (tok == "J") begin
                rc = $fscanf(fd, " %h", a);
                cycles += 2;
                if (apply) jtagWord(a);
            end else if (tok == "W") begin
                rc = $fscanf(fd, " %d", a);
                cycles += a;
                if (apply) begin
                    // a long enough idle line closes the packet
                    if (a >= `CFG_UART_IDLE_BITS * `CFG_UART_BIT_CYCLES) packetOpen = 1'b0;
                    repeat (a) @(posedge CLK);
                end
            end else if (tok == "E") begin
                rc = $fscanf(fd, " %h %h %h", a, b, c);
            end else if (tok == "L") begin
                rc = $fscanf(fd, " %h", a);
            end else begin
                $display("unknown record %s in the golden file", tok);
                driverErrors++;
                break;
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int budget;
        int waited;
        arstN           = 1'b0;
        Rx              = 1'b1;
        PSEL            = 1'b0;
        PENABLE         = 1'b0;
        PWRITE          = 1'b0;
        PADDR           = '0;
        PWDATA          = '0;
        jtagActive      = 1'b0;
        jtagWriteData   = '0;
        jtagWriteStrobe = 1'b0;
        driverErrors    = 0;
        cycleCount      = 0;
        cycleLimit      = 0;
        ledExpected     = 1'b0;
        packetOpen      = 1'b0;
        packetBytes     = 0;
        processGolden(1'b0, budget);
        cycleLimit = 2 * budget + 1000;
        repeat (8) @(posedge CLK);
        arstN <= 1'b1;
        processGolden(1'b1, budget);
        jtagActive <= 1'b0;
        // let the last long strobe reach the checker
        waited = 0;
        while (pendingCount != 0 && waited < 100) begin
            @(posedge CLK);
            waited++;
        end
        if (pendingCount != 0) begin
            $display("%0d expected records were never matched by the DUT", pendingCount);
        end
        $display("errors: driver %0d, checker %0d, unmatched %0d",
                 driverErrors, checkerErrors, pendingCount);
        if (driverErrors + checkerErrors + pendingCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: test/configChecker.sv
`timescale 1ns/1ps
`include "eFpgaConfig_cfg.svh"

module configChecker
    import configPkg::*;
(
    input  logic       CLK,
    input  configWordT configWriteData,
    input  logic       configWriteStrobe,
    input  frameAddrT  frameAddressRegister,
    input  rowSelT     rowSelect,
    input  logic       longFrameStrobe,
    output int         errorCount,
    output int         pendingCount
);

    localparam string  GoldenFile = "test/configGolden.txt";
    localparam rowSelT RowIdle    = `CFG_ROW_IDLE;

    logic       isLong[$];
    frameAddrT  expFrame[$];
    rowSelT     expRow[$];
    configWordT expData[$];
    logic       loadFailed = 1'b0;
    int         mismatches = 0;

    // only E and L records matter here
    initial begin
        int          fd;
        int          rc;
        string       tok;
        string       line;
        logic [31:0] f;
        logic [31:0] r;
        logic [31:0] d;
        fd = $fopen(GoldenFile, "r");
        if (fd == 0) begin
            $display("checker could not open %s", GoldenFile);
            loadFailed = 1'b1;
        end else begin
            while (1) begin
                rc = $fscanf(fd, " %s", tok);
                if (rc != 1) break;
                if (tok == "#") begin
                    rc = $fgets(line, fd);
                end else if (tok == "E" || tok == "L") begin
                    r = '0;
                    d = '0;
                    if (tok == "E") rc = $fscanf(fd, " %h %h %h", f, r, d);
                    else rc = $fscanf(fd, " %h", f);
                    isLong.push_back(tok == "L");
                    expFrame.push_back(f);
                    expRow.push_back(r[`CFG_ROW_SELECT_WIDTH-1:0]);
                    expData.push_back(d);
                end else if (tok == "A" || tok == "R") begin
                    rc = $fscanf(fd, " %h %h", f, r);
                end else begin
                    rc = $fscanf(fd, " %h", f);
                end
            end
            $fclose(fd);
        end
    end

    assign errorCount   = mismatches + (loadFailed ? 1 : 0);
    assign pendingCount = expFrame.size();

    task automatic compareEvent(input logic longEvent);
        if (expFrame.size() == 0) begin
            $display("** Error at %0t: %s with no expected record left", $time,
                     longEvent ? "long-frame strobe" : "row write");
            mismatches++;
            return;
        end
        if (isLong[0] != longEvent) begin
            $display("** Error at %0t: got %s, expected %s", $time,
                     longEvent ? "long-frame strobe" : "row write",
                     isLong[0] ? "long-frame strobe" : "row write");
            mismatches++;
        end else if (frameAddressRegister !== expFrame[0] || (!longEvent &&
                     (rowSelect !== expRow[0] || configWriteData !== expData[0]))) begin
            $display("** Error at %0t: frame %h row %0d data %h, expected %h %0d %h",
                     $time, frameAddressRegister, rowSelect, configWriteData,
                     expFrame[0], expRow[0], expData[0]);
            mismatches++;
        end
        void'(isLong.pop_front());
        void'(expFrame.pop_front());
        void'(expRow.pop_front());
        void'(expData.pop_front());
    endtask

    always @(posedge CLK) begin
        if (configWriteStrobe && rowSelect != RowIdle) compareEvent(1'b0);
        if (longFrameStrobe) compareEvent(1'b1);
    end

endmodule

// File: rtl/eFpgaConfig.sv
`timescale 1ns/1ps

module eFpgaConfig
    import configPkg::*;
(
    input  logic       CLK,
    input  logic       arstN,
    input  logic       Rx,
    input  logic       PSEL,
    input  logic       PENABLE,
    input  logic       PWRITE,
    input  apbAddrT    PADDR,
    input  configWordT PWDATA,
    output configWordT PRDATA,
    output logic       PREADY,
    output logic       PSLVERR,
    input  logic       jtagActive,
    input  configWordT jtagWriteData,
    input  logic       jtagWriteStrobe,
    output configWordT configWriteData,
    output logic       configWriteStrobe,
    output frameAddrT  frameAddressRegister,
    output rowSelT     rowSelect,
    output logic       longFrameStrobe,
    output logic       comActive,
    output logic       receiveLed
);

    configWordT uartWriteData;
    logic       uartWriteStrobe;
    logic       uartComActive;
    logic       uartLed;
    configWordT selfWriteData;
    logic       selfWriteStrobe;
    logic       configuring;
    logic       sourceActive;
    logic       sourceActiveDly;
    logic       sourceStart;

    configUart uartInst (
        .CLK        (CLK),
        .arstN      (arstN),
        .rx         (Rx),
        .writeData  (uartWriteData),
        .writeStrobe(uartWriteStrobe),
        .comActive  (uartComActive),
        .receiveLed (uartLed)
    );

    configApbPort apbInst (
        .CLK            (CLK),
        .arstN          (arstN),
        .psel           (PSEL),
        .penable        (PENABLE),
        .pwrite         (PWRITE),
        .paddr          (PADDR),
        .pwdata         (PWDATA),
        .comActive      (uartComActive),
        .jtagActive     (jtagActive),
        .configuring    (configuring),
        .prdata         (PRDATA),
        .pready         (PREADY),
        .pslverr        (PSLVERR),
        .selfWriteData  (selfWriteData),
        .selfWriteStrobe(selfWriteStrobe)
    );

    // jtag over uart over cpu, unselected words are lost
    assign configWriteData   = jtagActive    ? jtagWriteData   :
                               uartComActive ? uartWriteData   : selfWriteData;
    assign configWriteStrobe = jtagActive    ? jtagWriteStrobe :
                               uartComActive ? uartWriteStrobe : selfWriteStrobe;

    // rising edge of any external source restarts the fsm
    assign sourceActive = jtagActive || uartComActive;

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            sourceActiveDly <= 1'b0;
        end else begin
            sourceActiveDly <= sourceActive;
        end
    end

    assign sourceStart = sourceActive && !sourceActiveDly;

    configFsm fsmInst (
        .CLK                 (CLK),
        .arstN               (arstN),
        .writeData           (configWriteData),
        .writeStrobe         (configWriteStrobe),
        .restart             (sourceStart),
        .frameAddressRegister(frameAddressRegister),
        .rowSelect           (rowSelect),
        .longFrameStrobe     (longFrameStrobe),
        .configuring         (configuring)
    );

    assign comActive  = uartComActive;
    assign receiveLed = uartLed ^ jtagWriteStrobe;

endmodule

// File: rtl/configFsm.sv
`timescale 1ns/1ps
`include "eFpgaConfig_cfg.svh"

module configFsm
    import configPkg::*;
(
    input  logic       CLK,
    input  logic       arstN,
    input  configWordT writeData,
    input  logic       writeStrobe,
    input  logic       restart,
    output frameAddrT  frameAddressRegister,
    output rowSelT     rowSelect,
    output logic       longFrameStrobe,
    output logic       configuring
);

    localparam rowSelT LastRow = rowSelT'(`CFG_NUMBER_OF_ROWS - 1);
    localparam rowSelT RowIdle = `CFG_ROW_IDLE;

    fsmStateT state;
    logic     syncSeen;
    logic     desync;
    logic     lastRow;

    assign syncSeen = (writeData == `CFG_SYNC_WORD);
    assign desync   = writeData[`CFG_DESYNC_FLAG];
    assign lastRow  = (rowSelect == LastRow);

    // rowSelect doubles as the row counter
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            state                <= waitSync;
            rowSelect            <= RowIdle;
            frameAddressRegister <= '0;
            longFrameStrobe      <= 1'b0;
        end else begin
            longFrameStrobe <= 1'b0;
            if (restart) begin
                // new source took over, drop any frame in progress
                state     <= waitSync;
                rowSelect <= RowIdle;
            end else if (writeStrobe) begin
                case (state)
                    waitSync: begin
                        if (syncSeen) begin
                            state <= waitAddr;
                        end
                    end
                    waitAddr: begin
                        if (desync) begin
                            state <= waitSync;
                        end else begin
                            frameAddressRegister <= writeData[`CFG_FRAME_BITS_PER_ROW-1:0];
                            rowSelect            <= '0;
                            state                <= rowData;
                        end
                    end
                    rowData: begin
                        if (lastRow) begin
                            // frame complete, next word is another address
                            longFrameStrobe <= 1'b1;
                            rowSelect       <= RowIdle;
                            state           <= waitAddr;
                        end else begin
                            rowSelect <= rowSelect + 1'b1;
                        end
                    end
                    default: begin
                        state     <= waitSync;
                        rowSelect <= RowIdle;
                    end
                endcase
            end
        end
    end

    assign configuring = (state != waitSync);

endmodule

// File: rtl/configApbPort.sv
`timescale 1ns/1ps
`include "eFpgaConfig_cfg.svh"

module configApbPort
    import configPkg::*;
(
    input  logic       CLK,
    input  logic       arstN,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  apbAddrT    paddr,
    input  configWordT pwdata,
    input  logic       comActive,
    input  logic       jtagActive,
    input  logic       configuring,
    output configWordT prdata,
    output logic       pready,
    output logic       pslverr,
    output configWordT selfWriteData,
    output logic       selfWriteStrobe
);

    logic accessPhase;
    logic dataHit;
    logic statusHit;
    logic dataWrite;
    logic statusRead;

    assign accessPhase = psel && penable;
    assign dataHit     = (paddr == `CFG_APB_DATA_OFFSET);
    assign statusHit   = (paddr == `CFG_APB_STATUS_OFFSET);
    assign dataWrite   = accessPhase && pwrite && dataHit;
    assign statusRead  = accessPhase && !pwrite && statusHit;

    // zero wait states
    assign pready = 1'b1;

    // status is read-only, data reads back as zero
    assign pslverr = accessPhase && !(dataHit || statusRead);

    assign prdata = statusRead ? {29'd0, configuring, jtagActive, comActive} : '0;

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            selfWriteStrobe <= 1'b0;
        end else begin
            selfWriteStrobe <= dataWrite;
        end
    end

    always_ff @(posedge CLK) begin
        if (dataWrite) begin
            selfWriteData <= pwdata;
        end
    end

endmodule

// File: rtl/configUart.sv
`timescale 1ns/1ps
`include "eFpgaConfig_cfg.svh"

module configUart
    import configPkg::*;
(
    input  logic       CLK,
    input  logic       arstN,
    input  logic       rx,
    output configWordT writeData,
    output logic       writeStrobe,
    output logic       comActive,
    output logic       receiveLed
);

    localparam int BitCycles  = `CFG_UART_BIT_CYCLES;
    localparam int HalfBit    = BitCycles / 2;
    localparam int IdleCycles = `CFG_UART_IDLE_BITS * BitCycles;
    localparam int TimerWidth = $clog2(BitCycles);
    localparam int IdleWidth  = $clog2(IdleCycles + 1);

    localparam logic [TimerWidth-1:0] BitLast  = TimerWidth'(BitCycles - 1);
    localparam logic [TimerWidth-1:0] HalfLast = TimerWidth'(HalfBit - 1);
    localparam logic [IdleWidth-1:0]  IdleLast = IdleWidth'(IdleCycles - 1);

    logic                  rxMeta;
    logic                  rxSync;
    uartStateT             state;
    logic [TimerWidth-1:0] bitTimer;
    logic [2:0]            bitIndex;
    uartByteT              rxShift;
    logic [1:0]            byteCount;
    logic [IdleWidth-1:0]  idleCount;
    configWordT            wordShift;
    logic                  byteDone;
    logic                  idleTimeout;

    // two-flop synchronizer, line idles high
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            rxMeta <= 1'b1;
            rxSync <= 1'b1;
        end else begin
            rxMeta <= rx;
            rxSync <= rxMeta;
        end
    end

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            state    <= idle;
            bitTimer <= '0;
            bitIndex <= '0;
        end else begin
            case (state)
                idle: begin
                    bitTimer <= '0;
                    bitIndex <= '0;
                    if (!rxSync) begin
                        state <= start;
                    end
                end
                start: begin
                    if (bitTimer == HalfLast) begin
                        bitTimer <= '0;
                        // low pulse shorter than half a bit is a glitch
                        state    <= rxSync ? idle : data;
                    end else begin
                        bitTimer <= bitTimer + 1'b1;
                    end
                end
                data: begin
                    if (bitTimer == BitLast) begin
                        bitTimer <= '0;
                        bitIndex <= bitIndex + 1'b1;
                        if (bitIndex == 3'd7) begin
                            state <= stop;
                        end
                    end else begin
                        bitTimer <= bitTimer + 1'b1;
                    end
                end
                default: begin
                    // stop bit, sampled at its middle
                    if (bitTimer == BitLast) begin
                        bitTimer <= '0;
                        state    <= idle;
                    end else begin
                        bitTimer <= bitTimer + 1'b1;
                    end
                end
            endcase
        end
    end

    // lsb arrives first on the line
    always_ff @(posedge CLK) begin
        if (state == data && bitTimer == BitLast) begin
            rxShift <= {rxSync, rxShift[7:1]};
        end
    end

    // framing error drops the byte
    assign byteDone    = (state == stop) && (bitTimer == BitLast) && rxSync;
    assign idleTimeout = comActive && rxSync && (idleCount == IdleLast);

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            comActive   <= 1'b0;
            byteCount   <= '0;
            idleCount   <= '0;
            writeStrobe <= 1'b0;
            receiveLed  <= 1'b0;
        end else begin
            writeStrobe <= 1'b0;
            if (!comActive || !rxSync) begin
                idleCount <= '0;
            end else begin
                idleCount <= idleCount + 1'b1;
            end
            if (idleTimeout) begin
                // end of packet, partial word discarded
                comActive <= 1'b0;
                byteCount <= '0;
            end else if (byteDone) begin
                if (!comActive) begin
                    if (rxShift == `CFG_UART_START_BYTE) begin
                        comActive <= 1'b1;
                        byteCount <= '0;
                    end
                end else begin
                    byteCount <= byteCount + 1'b1;
                    if (byteCount == 2'd3) begin
                        writeStrobe <= 1'b1;
                        receiveLed  <= ~receiveLed;
                    end
                end
            end
        end
    end

    // msb first packing
    always_ff @(posedge CLK) begin
        if (byteDone && comActive) begin
            wordShift <= {wordShift[23:0], rxShift};
        end
    end

    assign writeData = wordShift;

endmodule

// File: rtl/configPkg.sv
`include "eFpgaConfig_cfg.svh"

package configPkg;

    // configuration word as seen by the fabric
    typedef logic [31:0] configWordT;

    typedef logic [`CFG_FRAME_BITS_PER_ROW-1:0] frameAddrT;
    typedef logic [`CFG_ROW_SELECT_WIDTH-1:0] rowSelT;

    typedef logic [7:0] uartByteT;
    typedef logic [7:0] apbAddrT;

    // 8N1 receiver phases
    typedef enum logic [1:0] {
        idle,
        start,
        data,
        stop
    } uartStateT;

    typedef enum logic [1:0] {
        waitSync,
        waitAddr,
        rowData
    } fsmStateT;

endpackage

// File: include/eFpgaConfig_cfg.svh
`ifndef EFPGA_CONFIG_CFG_SVH
`define EFPGA_CONFIG_CFG_SVH

// fabric geometry
`define CFG_NUMBER_OF_ROWS      16
`define CFG_ROW_SELECT_WIDTH    5
`define CFG_FRAME_BITS_PER_ROW  32

// address word bit that ends a configuration session
`define CFG_DESYNC_FLAG         20

// word that opens a configuration session
`define CFG_SYNC_WORD           32'hFAB0_FAB1

// all-ones row select, no row driven
`define CFG_ROW_IDLE            {`CFG_ROW_SELECT_WIDTH{1'b1}}

// uart line timing and framing
`define CFG_UART_BIT_CYCLES     8
`define CFG_UART_IDLE_BITS      24
`define CFG_UART_START_BYTE     8'h81

// apb register map
`define CFG_APB_DATA_OFFSET     8'h00
`define CFG_APB_STATUS_OFFSET   8'h04

`endif
